// File: hw/copper_pkg.sv
// shared copper definitions
// word and enum types, register map, id value and widths
package copper_pkg;

    // copper memory word, opcode in [15:12], operand in [11:0]
    typedef logic [15:0] word_t;

    // instruction opcodes, unlisted codes fall through as nop
    typedef enum logic [3:0] {
        NOP   = 4'h0,
        WAITV = 4'h1,
        WAITH = 4'h2,
        MOVE  = 4'h3,
        END   = 4'hF
    } copper_op_e;

    // engine FSM states
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        WAIT_BEAM,
        MOVE_DATA,
        HALT
    } copper_state_e;

    // AXI4-Lite byte address width
    localparam int AXI_AW = 13;

    // register map, byte offsets
    localparam logic [AXI_AW-1:0] CTRL_ADDR   = 13'h000;
    localparam logic [AXI_AW-1:0] STATUS_ADDR = 13'h004;
    localparam logic [AXI_AW-1:0] ID_ADDR     = 13'h008;
    localparam logic [AXI_AW-1:0] MEM_BASE    = 13'h1000;

    // read-only identification, "COP" plus revision 1
    localparam logic [31:0] COPPER_ID = 32'h434F5001;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // beam coordinate width
    localparam int BEAM_W = 12;

endpackage

// File: hw/copper_mem_if.sv
// copper memory port bundle
// host write port, engine read port and memory side
`timescale 1ns/1ps

interface copper_mem_if import copper_pkg::*; #(
    parameter int AWIDTH = 10
) ();

    // write port, driven by the host block
    logic              wr_en;
    logic [AWIDTH-1:0] wr_addr;
    word_t             wr_data;

    // read port, address from the engine, data from the memory
    logic [AWIDTH-1:0] rd_addr;
    word_t             rd_data;

    modport writer (output wr_en, output wr_addr, output wr_data);

    modport reader (output rd_addr, input rd_data);

    modport mem (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);

endinterface

// File: hw/copper_mem.sv
// copper program memory
// dual-port block ram with registered read and write forwarding
`timescale 1ns/1ps

module copper_mem import copper_pkg::*; #(
    parameter int AWIDTH = 10
) (
    input logic       clk,
    copper_mem_if.mem mem_if
);

    localparam int DEPTH = 2 ** AWIDTH;

    // one word per instruction or move data
    word_t bram [0:DEPTH-1];

    // write port, host side
    always_ff @(posedge clk) begin
        if (mem_if.wr_en) begin
            bram[mem_if.wr_addr] <= mem_if.wr_data;
        end
    end

    // read port, engine side
    // a write to the address being read returns the new word,
    // as the block ram does in write-through mode
    always_ff @(posedge clk) begin
        if (mem_if.wr_en && (mem_if.wr_addr == mem_if.rd_addr)) begin
            mem_if.rd_data <= mem_if.wr_data;
        end else begin
            mem_if.rd_data <= bram[mem_if.rd_addr];
        end
    end

endmodule

// File: hw/copper_axil_regs.sv
// AXI4-Lite host block for the copper
// ctrl, status and id registers plus the program memory write window
`timescale 1ns/1ps

module copper_axil_regs import copper_pkg::*; #(
    parameter int AWIDTH = 10
) (
    input  logic              clk,
    input  logic              rst_n_i,
    // write address and data
    input  logic [AXI_AW-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  logic [31:0]       wdata_i,
    input  logic              wvalid_i,
    output logic              wready_o,
    // write response
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,
    // read address
    input  logic [AXI_AW-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    // read data
    output logic [31:0]       rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i,
    // engine side
    input  logic [AWIDTH-1:0] pc_i,
    input  logic              running_i,
    output logic              enable_o,
    // memory write port
    copper_mem_if.writer      mem_if
);

    // window size in bytes, one word per 32-bit slot
    localparam int MEM_BYTES = 4 * (2 ** AWIDTH);

    logic              aw_hs;
    logic              ar_hs;
    logic [AXI_AW-1:0] wr_off;
    logic              wr_in_mem;
    logic              wr_ok;
    logic [31:0]       status_word;
    logic [31:0]       rd_word;
    logic              rd_ok;

    // accept only with address and data together and no response pending
    assign aw_hs     = awvalid_i && wvalid_i && !bvalid_o;
    assign awready_o = aw_hs;
    assign wready_o  = aw_hs;

    assign ar_hs     = arvalid_i && !rvalid_o;
    assign arready_o = ar_hs;

    // memory window decode
    assign wr_off    = awaddr_i - MEM_BASE;
    assign wr_in_mem = (awaddr_i >= MEM_BASE) && (32'(wr_off) < MEM_BYTES);
    // only ctrl and the memory window are writable
    assign wr_ok     = (awaddr_i == CTRL_ADDR) || wr_in_mem;

    // memory written on the acceptance edge, low half of the data bus
    assign mem_if.wr_en   = aw_hs && wr_in_mem;
    assign mem_if.wr_addr = wr_off[AWIDTH+1:2];
    assign mem_if.wr_data = wdata_i[15:0];

    // status: running in bit 0, pc from bit 16 up
    always_comb begin
        status_word                = '0;
        status_word[0]             = running_i;
        status_word[16 +: AWIDTH]  = pc_i;
    end

    // read mux, memory window is write only
    always_comb begin
        rd_word = '0;
        rd_ok   = 1'b1;
        case (araddr_i)
            CTRL_ADDR:   rd_word = {31'b0, enable_o};
            STATUS_ADDR: rd_word = status_word;
            ID_ADDR:     rd_word = COPPER_ID;
            default:     rd_ok = 1'b0;
        endcase
    end

    // write channel control and ctrl register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bvalid_o <= 1'b0;
            enable_o <= 1'b0;
        end else begin
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (aw_hs) begin
                bvalid_o <= 1'b1;
                if (awaddr_i == CTRL_ADDR) begin
                    enable_o <= wdata_i[0];
                end
            end
        end
    end

    // read channel control
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rvalid_o <= 1'b0;
        end else if (ar_hs) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    // response payload, held while valid waits for ready
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (ar_hs) begin
            rdata_o <= rd_word;
            rresp_o <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// File: hw/copper_engine.sv
// copper execution engine
// fetch and decode FSM, beam waits and timed register writes
`timescale 1ns/1ps

module copper_engine import copper_pkg::*; #(
    parameter int AWIDTH = 10,
    parameter int REG_AW = 8
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              enable_i,
    input  logic              frame_start_i,
    input  logic [BEAM_W-1:0] h_pos_i,
    input  logic [BEAM_W-1:0] v_pos_i,
    // program memory read port
    copper_mem_if.reader      mem_if,
    // video register write port
    output logic              reg_wr_o,
    output logic [REG_AW-1:0] reg_addr_o,
    output word_t             reg_data_o,
    output logic              running_o,
    output logic [AWIDTH-1:0] pc_o
);

    copper_state_e     state;
    copper_op_e        opcode;
    logic [AWIDTH-1:0] pc;
    logic              wait_vert;
    logic [BEAM_W-1:0] wait_pos;
    logic              beam_reached;

    // memory always reads at pc, data is valid one cycle later
    assign mem_if.rd_addr = pc;
    assign opcode         = copper_op_e'(mem_if.rd_data[15:12]);

    assign pc_o      = pc;
    assign running_o = (state != IDLE) && (state != HALT);

    // beam at or past the waited line or column
    assign beam_reached = wait_vert ? (v_pos_i >= wait_pos) : (h_pos_i >= wait_pos);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state    <= IDLE;
            pc       <= '0;
            reg_wr_o <= 1'b0;
        end else begin
            // write strobe is a single cycle pulse
            reg_wr_o <= 1'b0;
            if (!enable_i) begin
                state <= IDLE;
            end else if (frame_start_i) begin
                // every frame restarts at word 0
                pc    <= '0;
                state <= FETCH;
            end else begin
                case (state)
                    FETCH: begin
                        // address issued this cycle, pc moves on
                        pc    <= pc + 1'b1;
                        state <= DECODE;
                    end
                    DECODE: begin
                        case (opcode)
                            WAITV, WAITH: state <= WAIT_BEAM;
                            MOVE: begin
                                // pc already points at the data word
                                pc    <= pc + 1'b1;
                                state <= MOVE_DATA;
                            end
                            END:     state <= HALT;
                            default: state <= FETCH;
                        endcase
                    end
                    WAIT_BEAM: begin
                        if (beam_reached) begin
                            state <= FETCH;
                        end
                    end
                    MOVE_DATA: begin
                        reg_wr_o <= 1'b1;
                        state    <= FETCH;
                    end
                    // idle and halt only leave on frame start
                    default: state <= state;
                endcase
            end
        end
    end

    // operand capture
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            wait_vert <= (opcode == WAITV);
            wait_pos  <= mem_if.rd_data[BEAM_W-1:0];
            if (opcode == MOVE) begin
                // low operand bits select the video register
                reg_addr_o <= mem_if.rd_data[REG_AW-1:0];
            end
        end
        if (state == MOVE_DATA) begin
            reg_data_o <= mem_if.rd_data;
        end
    end

endmodule

// File: hw/copper_top.sv
// copper subsystem top level
// host register block, program memory and execution engine
`timescale 1ns/1ps

module copper_top import copper_pkg::*; #(
    parameter int AWIDTH = 10,
    parameter int REG_AW = 8
) (
    input  logic              clk,
    input  logic              rst_n_i,
    // AXI4-Lite slave
    input  logic [AXI_AW-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  logic [31:0]       wdata_i,
    input  logic              wvalid_i,
    output logic              wready_o,
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,
    input  logic [AXI_AW-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output logic [31:0]       rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i,
    // beam position from video timing
    input  logic              frame_start_i,
    input  logic [BEAM_W-1:0] h_pos_i,
    input  logic [BEAM_W-1:0] v_pos_i,
    // video register writes
    output logic              reg_wr_o,
    output logic [REG_AW-1:0] reg_addr_o,
    output word_t             reg_data_o
);

    // ctrl enable, engine status back to the host
    logic              ctrl_enable;
    logic              engine_running;
    logic [AWIDTH-1:0] engine_pc;

    copper_mem_if #(.AWIDTH(AWIDTH)) mem_if ();

    copper_axil_regs #(
        .AWIDTH (AWIDTH)
    ) u_regs (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .pc_i      (engine_pc),
        .running_i (engine_running),
        .enable_o  (ctrl_enable),
        .mem_if    (mem_if.writer)
    );

    copper_mem #(
        .AWIDTH (AWIDTH)
    ) u_mem (
        .clk    (clk),
        .mem_if (mem_if.mem)
    );

    copper_engine #(
        .AWIDTH (AWIDTH),
        .REG_AW (REG_AW)
    ) u_engine (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (ctrl_enable),
        .frame_start_i (frame_start_i),
        .h_pos_i       (h_pos_i),
        .v_pos_i       (v_pos_i),
        .mem_if        (mem_if.reader),
        .reg_wr_o      (reg_wr_o),
        .reg_addr_o    (reg_addr_o),
        .reg_data_o    (reg_data_o),
        .running_o     (engine_running),
        .pc_o          (engine_pc)
    );

endmodule

// File: tests/copper_checker.sv
// register write checker for the copper testbench
// expected writes and beam limits from the stimulus file, value compare task
`timescale 1ns/1ps

module copper_checker (
    input logic        clk,
    input logic        rst_n_i,
    input logic        frame_start_i,
    input logic [11:0] h_pos_i,
    input logic [11:0] v_pos_i,
    input logic        reg_wr_i,
    input logic [7:0]  reg_addr_i,
    input logic [15:0] reg_data_i,
    input logic        allow_i
);

    logic [15:0] stim [0:63];
    logic [15:0] exp_addr [0:15];
    logic [15:0] exp_data [0:15];
    // earliest beam position allowed for each write
    logic [23:0] min_pos [0:15];
    int n_exp;
    int idx;
    int err_count;
    int check_count;
    int seq_count;
    int write_count;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        err_count++;
        $display("failure: %s", msg);
    endtask

    // walk the program, beam waits move the earliest position forward
    task automatic build_expected();
        int n_prog;
        int k;
        logic [11:0] cur_v;
        logic [11:0] cur_h;
        n_prog = stim[0];
        n_exp  = stim[n_prog+1];
        k      = 0;
        cur_v  = '0;
        cur_h  = '0;
        for (int i = 1; i <= n_prog; i++) begin
            case (stim[i][15:12])
                4'h1: begin
                    cur_v = stim[i][11:0];
                    cur_h = '0;
                end
                4'h2: cur_h = stim[i][11:0];
                4'h3: begin
                    min_pos[k] = {cur_v, cur_h};
                    k++;
                    i++;
                end
                default: ;
            endcase
        end
        for (int j = 0; j < n_exp; j++) begin
            exp_addr[j] = stim[n_prog+2+2*j];
            exp_data[j] = stim[n_prog+3+2*j];
        end
    endtask

    initial begin
        err_count   = 0;
        check_count = 0;
        seq_count   = 0;
        write_count = 0;
        idx         = 0;
        $readmemh("tests/copper_stimulus.mem", stim);
        build_expected();
    end

    // outputs are registered, so the pre-edge values line up with the beam
    always @(posedge clk) begin
        if (!rst_n_i) begin
            idx = 0;
        end else begin
            if (reg_wr_i) begin
                write_count++;
                if (!allow_i) begin
                    report_failure("register write while the engine is disabled");
                end else if (idx >= n_exp) begin
                    report_failure("register write after END before the next frame");
                end else begin
                    check_value("move_exec addr", {24'b0, exp_addr[idx][7:0]}, {24'b0, reg_addr_i});
                    check_value("move_exec data", {16'b0, exp_data[idx]}, {16'b0, reg_data_i});
                    check_count++;
                    if ({v_pos_i, h_pos_i} < min_pos[idx]) begin
                        report_failure($sformatf("write %0d at line %0d column %0d is before its beam wait",
                            idx, v_pos_i, h_pos_i));
                    end
                    idx++;
                    if (idx == n_exp) begin
                        seq_count++;
                    end
                end
            end
            if (frame_start_i) begin
                if (idx != 0 && idx != n_exp) begin
                    report_failure("new frame started before the write sequence was complete");
                end
                idx = 0;
            end
        end
    end

endmodule

// File: tests/copper_tb.sv
// copper testbench top
// clock, reset, beam counters, AXI4-Lite driver, program loader and report
`timescale 1ns/1ps

module copper_tb import copper_pkg::*; ();

    localparam int AW      = 6;
    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        rst_n;
    logic [12:0] awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [11:0] h_pos, v_pos;
    logic        frame_start;
    logic        reg_wr;
    logic [7:0]  reg_addr;
    word_t       reg_data;
    logic        allow_writes;
    logic        timed_out;
    logic [15:0] stim [0:63];
    logic [31:0] data;
    logic [1:0]  resp;
    int          errs_before;
    int          writes_before;

    copper_top #(.AWIDTH(AW), .REG_AW(8)) u_dut (
        .clk(clk), .rst_n_i(rst_n),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wvalid_i(wvalid), .wready_o(wready),
        .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready),
        .frame_start_i(frame_start), .h_pos_i(h_pos), .v_pos_i(v_pos),
        .reg_wr_o(reg_wr), .reg_addr_o(reg_addr), .reg_data_o(reg_data)
    );

    copper_checker u_checker (
        .clk(clk), .rst_n_i(rst_n), .frame_start_i(frame_start),
        .h_pos_i(h_pos), .v_pos_i(v_pos), .reg_wr_i(reg_wr),
        .reg_addr_i(reg_addr), .reg_data_i(reg_data), .allow_i(allow_writes)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // 16 columns by 8 lines, one column per clock
    always @(posedge clk) begin
        if (!rst_n) begin
            h_pos <= '0;
            v_pos <= '0;
        end else begin
            h_pos <= (h_pos == 15) ? '0 : h_pos + 1'b1;
            if (h_pos == 15) begin
                v_pos <= (v_pos == 7) ? '0 : v_pos + 1'b1;
            end
        end
    end
    assign frame_start = rst_n && (h_pos == 0) && (v_pos == 0);

    // checker mismatches plus failed assertions
    function automatic int error_total();
        return u_checker.err_count + u_dut.u_assert.fail_count;
    endfunction

    task automatic note_timeout(input string what);
        $display("timeout: %s never happened", what);
        timed_out = 1'b1;
    endtask

    task automatic axi_write(input logic [12:0] a, input logic [31:0] d, output logic [1:0] r);
        int n;
        r = 2'bxx;
        if (timed_out) return;
        @(posedge clk);
        awaddr  <= a;
        wdata   <= d;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(awready && wready) && n < TIMEOUT);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!(awready && wready)) begin
            note_timeout("write address and data acceptance");
            return;
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!bvalid && n < TIMEOUT);
        if (!bvalid) note_timeout("write response");
        r = bresp;
        // response waits one cycle for bready
        @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
    endtask

    task automatic axi_read(input logic [12:0] a, output logic [31:0] d, output logic [1:0] r);
        int n;
        d = 'x;
        r = 2'bxx;
        if (timed_out) return;
        @(posedge clk);
        araddr  <= a;
        arvalid <= 1'b1;
        rready  <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!arready && n < TIMEOUT);
        @(posedge clk);
        arvalid <= 1'b0;
        if (!arready) begin
            note_timeout("read address acceptance");
            return;
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rvalid && n < TIMEOUT);
        if (!rvalid) note_timeout("read response");
        d = rdata;
        r = rresp;
        // response waits one cycle for rready
        @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
    endtask

    task automatic wait_sequences(input int target);
        int n;
        n = 0;
        while (!timed_out && u_checker.seq_count < target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!timed_out && u_checker.seq_count < target) note_timeout("complete write sequence");
    endtask

    task automatic wait_frame_starts(input int count);
        int n;
        int seen;
        n = 0;
        seen = 0;
        while (!timed_out && seen < count && n < TIMEOUT) begin
            @(negedge clk);
            if (frame_start) seen++;
            n++;
        end
        if (!timed_out && seen < count) note_timeout("frame start");
    endtask

    task automatic end_test(input string name);
        int diff;
        diff = error_total() - errs_before;
        $display("test %s: %s, %0d errors", name, (diff == 0) ? "ok" : "bad", diff);
        errs_before = error_total();
    endtask

    initial begin
        awaddr = '0;
        wdata = '0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        h_pos = '0;
        v_pos = '0;
        allow_writes = 1'b0;
        timed_out = 1'b0;
        errs_before = 0;
        rst_n = 1'b0;
        $readmemh("tests/copper_stimulus.mem", stim);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        u_checker.check_value("reset_state reg_wr", 0, reg_wr);
        u_checker.check_value("reset_state bvalid", 0, bvalid);
        u_checker.check_value("reset_state rvalid", 0, rvalid);
        axi_read(ID_ADDR, data, resp);
        u_checker.check_value("reset_state id", COPPER_ID, data);
        u_checker.check_value("reset_state id resp", RESP_OKAY, resp);
        axi_read(CTRL_ADDR, data, resp);
        u_checker.check_value("reset_state ctrl", 0, data);
        end_test("reset_state");

        // only bit 0 of ctrl is stored
        axi_write(CTRL_ADDR, 32'hFFFF_FFFE, resp);
        u_checker.check_value("register_map ctrl resp", RESP_OKAY, resp);
        axi_read(CTRL_ADDR, data, resp);
        u_checker.check_value("register_map ctrl", 0, data);
        axi_write(ID_ADDR, 32'h1, resp);
        u_checker.check_value("register_map id write", RESP_SLVERR, resp);
        axi_write(STATUS_ADDR, 32'h1, resp);
        u_checker.check_value("register_map status write", RESP_SLVERR, resp);
        axi_write(13'h00C, 32'h1, resp);
        u_checker.check_value("register_map unmapped write", RESP_SLVERR, resp);
        axi_read(MEM_BASE, data, resp);
        u_checker.check_value("register_map mem read", RESP_SLVERR, resp);
        u_checker.check_value("register_map mem read data", 0, data);
        axi_read(13'h00C, data, resp);
        u_checker.check_value("register_map unmapped read", RESP_SLVERR, resp);
        axi_read(STATUS_ADDR, data, resp);
        u_checker.check_value("register_map status running", 0, data[0]);
        end_test("register_map");

        for (int i = 0; i < stim[0]; i++) begin
            axi_write(MEM_BASE + 13'(4 * i), {16'b0, stim[i+1]}, resp);
            u_checker.check_value("move_exec load resp", RESP_OKAY, resp);
        end
        allow_writes <= 1'b1;
        axi_write(CTRL_ADDR, 32'h1, resp);
        axi_read(CTRL_ADDR, data, resp);
        u_checker.check_value("move_exec ctrl", 1, data);
        wait_sequences(1);
        end_test("move_exec");

        wait_sequences(2);
        end_test("beam_waits");

        wait_sequences(3);
        axi_write(CTRL_ADDR, 32'h0, resp);
        allow_writes <= 1'b0;
        writes_before = u_checker.write_count;
        wait_frame_starts(2);
        u_checker.check_value("end_restart writes", writes_before, u_checker.write_count);
        end_test("end_restart");

        $display("tests 5, checks %0d, errors %0d", u_checker.check_count, error_total());
        if (timed_out || error_total() != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

// File: tests/copper_assert.sv
// protocol and control assertions for the copper top level
// response hold, single cycle register strobe, no writes while disabled
`timescale 1ns/1ps

module copper_assert (
    input logic clk,
    input logic rst_n_i,
    input logic bvalid_o,
    input logic bready_i,
    input logic rvalid_o,
    input logic rready_i,
    input logic reg_wr_o,
    input logic enable_i
);

    // number of failed assertions
    int fail_count;

    initial fail_count = 0;

    // responses stay up until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    a_reg_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_wr_o |=> !reg_wr_o)
        else begin
            fail_count++;
            $error("reg_wr held longer than one cycle");
        end

    // strobe is registered, so it trails enable by one cycle
    a_no_wr_disabled: assert property (@(posedge clk) disable iff (!rst_n_i)
        !enable_i |=> !reg_wr_o)
        else begin
            fail_count++;
            $error("reg_wr while enable is clear");
        end

endmodule

bind copper_top copper_assert u_assert (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .bvalid_o (bvalid_o),
    .bready_i (bready_i),
    .rvalid_o (rvalid_o),
    .rready_i (rready_i),
    .reg_wr_o (reg_wr_o),
    .enable_i (ctrl_enable)
);

// File: tests/copper_stimulus.mem
// copper program words and expected video register writes, 16-bit hex words
// layout: program length, program words, write count, then address and data pairs
000E
3010 // move to reg 0x10
1234
1002 // wait for line 2
2005 // then column 5
3011 // move to reg 0x11
ABCD
1004 // wait for line 4
3022 // move to reg 0x22
5A5A
200C // wait for column 12
3033 // move to reg 0x33
0F0F
7000 // unused code, runs as nop
F000 // end of program
0004
0010
1234
0011
ABCD
0022
5A5A
0033
0F0F

// File: vlog.f
hw/copper_pkg.sv
hw/copper_mem_if.sv
hw/copper_mem.sv
hw/copper_axil_regs.sv
hw/copper_engine.sv
hw/copper_top.sv
tests/copper_checker.sv
tests/copper_tb.sv
tests/copper_assert.sv

// File: Bender.yml
package:
  name: copper

sources:
  - files:
      - hw/copper_pkg.sv
      - hw/copper_mem_if.sv
      - hw/copper_mem.sv
      - hw/copper_axil_regs.sv
      - hw/copper_engine.sv
      - hw/copper_top.sv
  - target: test
    files:
      - tests/copper_checker.sv
      - tests/copper_tb.sv
      - tests/copper_assert.sv
